/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_lsu
FILELIST  = build.f
PASS_MSG  = STATUS: PASS
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* build.f */
rtl/lsu_pkg.sv
rtl/lsu_request.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
testbench/lsu_sva.sv
testbench/tb_lsu.sv

/* rtl/lsu_pkg.sv */
// Load/store unit shared types
package lsu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int XLEN = 32;         // Data and address width
  localparam int BE_W = XLEN / 8;   // Byte lanes per word

  typedef logic [XLEN-1:0] word_t;  // One data or address word
  typedef logic [BE_W-1:0] be_t;    // One byte-enable vector

  // Access size, encoded as on the issue side
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Request as presented by the EX stage
  typedef struct packed {
    logic       en;          // Load or store present
    logic       we;          // Store
    lsu_size_e  size;
    logic       sign_ext;    // Sign extend loaded byte/halfword
    logic       second;      // Second phase of a misaligned access
    logic       use_incr;    // Address is base + incr
    word_t      base;
    word_t      incr;
    logic [1:0] reg_offset;  // Byte offset of store data in the register
    word_t      wdata;
  } lsu_req_t;

  // Bus request payload
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } bus_req_t;

  // Control carried over to write-back, one entry per accepted access
  typedef struct packed {
    lsu_size_e  size;
    logic       sign_ext;
    logic       we;
    logic [1:0] offset;   // Byte offset of the access address
    logic       last;     // Final phase, result goes to write-back
  } wb_ctrl_t;

endpackage

/* rtl/lsu_rdata_align.sv */
// Load data alignment and extension
module lsu_rdata_align (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::wb_ctrl_t wb_ctrl_i,      // Control of the responding access
  input  logic              first_phase_i,  // Split access, first response
  input  logic              bus_rvalid_i,
  input  lsu_pkg::word_t    bus_rdata_i,
  output lsu_pkg::word_t    wb_rdata_o
);

  import lsu_pkg::*;

  word_t             rdata_q;     // Raw first word, or last result
  word_t             lane_shift;  // New word moved down to lane 0
  logic [2*XLEN-1:0] pair_shift;  // New word over held word, moved down
  logic [7:0]        byte_sel;
  logic [15:0]       half_sel;
  word_t             word_sel;
  word_t             rdata_ext;

  ////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////

  assign lane_shift = bus_rdata_i >> (8 * wb_ctrl_i.offset);

  // Held word carries the low part of a split access, new word the high part
  assign pair_shift = {bus_rdata_i, rdata_q} >> (8 * wb_ctrl_i.offset);

  assign byte_sel = lane_shift[7:0];   // A byte never splits

  always_comb
  begin
    if (wb_ctrl_i.offset == 2'b11)
      half_sel = pair_shift[15:0];     // Lane 3 of held word, lane 0 of new
    else
      half_sel = lane_shift[15:0];
  end

  always_comb
  begin
    if (wb_ctrl_i.offset == 2'b00)
      word_sel = bus_rdata_i;          // Aligned
    else
      word_sel = pair_shift[XLEN-1:0]; // Assembled from both responses
  end

  ////////////////////////////////////////
  // Extension
  ////////////////////////////////////////

  always_comb
  begin
    case (wb_ctrl_i.size)
      SIZE_BYTE:
      begin
        rdata_ext = {{(XLEN-8){wb_ctrl_i.sign_ext & byte_sel[7]}}, byte_sel};
      end
      SIZE_HALF:
      begin
        rdata_ext = {{(XLEN-16){wb_ctrl_i.sign_ext & half_sel[15]}}, half_sel};
      end
      default:
      begin
        rdata_ext = word_sel;
      end
    endcase
  end

  ////////////////////////////////////////
  // Held word
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (bus_rvalid_i && !wb_ctrl_i.we)  // Loads only
    begin
      if (first_phase_i)
        rdata_q <= bus_rdata_i;  // Kept for assembly with the next response
      else
        rdata_q <= rdata_ext;
    end
  end

  // Live result in the response cycle, last result otherwise
  assign wb_rdata_o = bus_rvalid_i ? rdata_ext : rdata_q;

endmodule

/* rtl/lsu_request.sv */
// Load/store request formation
module lsu_request (
  input  lsu_pkg::lsu_req_t ex_req_i,      // Request from EX
  output lsu_pkg::bus_req_t bus_o,         // Bus payload
  output logic              misaligned_o,  // First phase needs a second one
  output logic [1:0]        offset_o       // Byte offset of the address
);

  import lsu_pkg::*;

  word_t             addr;       // Effective address
  be_t               be;
  logic [1:0]        wdata_rot;  // Lanes to rotate store data by
  logic [2*XLEN-1:0] wdata_dbl;  // Doubled store data, shifted
  word_t             wdata;

  ////////////////////////////////////////
  // Address
  ////////////////////////////////////////

  assign addr     = ex_req_i.use_incr ? (ex_req_i.base + ex_req_i.incr)
                                      : ex_req_i.base;
  assign offset_o = addr[1:0];

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  // Left shifts truncate to BE_W lanes, so upper lanes fall off the word
  always_comb
  begin
    case (ex_req_i.size)
      SIZE_BYTE:
      begin
        be = be_t'(4'b0001) << addr[1:0];     // Single lane
      end
      SIZE_HALF:
      begin
        if (ex_req_i.second)
          be = 4'b0001;                        // Upper byte spilled into next word
        else
          be = be_t'(4'b0011) << addr[1:0];   // Offset 3 keeps only lane 3
      end
      default:
      begin
        if (ex_req_i.second)
          be = ~(be_t'(4'b1111) << addr[1:0]); // Low lanes left over
        else
          be = be_t'(4'b1111) << addr[1:0];    // Lanes from offset up
      end
    endcase
  end

  ////////////////////////////////////////
  // Store data rotation
  ////////////////////////////////////////

  // Register byte reg_offset lands on memory lane addr[1:0]
  assign wdata_rot = addr[1:0] - ex_req_i.reg_offset;

  // Rotate left by wdata_rot lanes, taken from the doubled word
  assign wdata_dbl = {ex_req_i.wdata, ex_req_i.wdata} >> (XLEN - 8 * wdata_rot);
  assign wdata     = wdata_dbl[XLEN-1:0];

  ////////////////////////////////////////
  // Misalignment
  ////////////////////////////////////////

  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_req_i.en && !ex_req_i.second)   // Only the first phase can split
    begin
      case (ex_req_i.size)
        SIZE_BYTE: misaligned_o = 1'b0;
        SIZE_HALF: misaligned_o = (addr[1:0] == 2'b11);  // Crosses the word
        default:   misaligned_o = (addr[1:0] != 2'b00);
      endcase
    end
  end

  ////////////////////////////////////////
  // Bus payload
  ////////////////////////////////////////

  // Second phase always starts at lane 0 of the next word
  assign bus_o.addr  = ex_req_i.second ? {addr[XLEN-1:2], 2'b00} : addr;
  assign bus_o.we    = ex_req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata;

endmodule

/* rtl/lsu_top.sv */
// Load/store unit top level
module lsu_top #(
  parameter int DEPTH = 2   // Max outstanding bus transactions
) (
  input  logic              clk,
  input  logic              rst_n,

  // EX stage
  input  lsu_pkg::lsu_req_t ex_req_i,
  output logic              ex_misaligned_o,
  output logic              ex_ready_o,

  // Data bus
  output logic              bus_req_o,
  output lsu_pkg::bus_req_t bus_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  lsu_pkg::word_t    bus_rdata_i,
  input  logic              bus_err_i,

  // WB stage
  output logic              wb_valid_o,
  output lsu_pkg::word_t    wb_rdata_o,
  output logic              wb_err_o,
  output lsu_pkg::word_t    wb_addr_o,
  output logic              busy_o
);

  import lsu_pkg::*;

  logic [1:0] offset;   // Address byte offset from request side
  wb_ctrl_t   wb_ctrl;  // Control of the access in WB

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  lsu_request u_request (
    .ex_req_i     (ex_req_i),
    .bus_o        (bus_o),
    .misaligned_o (ex_misaligned_o),
    .offset_o     (offset)
  );

  ////////////////////////////////////////
  // Counter and handshakes
  ////////////////////////////////////////

  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) u_txn_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_req_i     (ex_req_i),
    .misaligned_i (ex_misaligned_o),
    .offset_i     (offset),
    .bus_addr_i   (bus_o.addr),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_err_i    (bus_err_i),
    .bus_req_o    (bus_req_o),
    .ex_ready_o   (ex_ready_o),
    .wb_valid_o   (wb_valid_o),
    .wb_err_o     (wb_err_o),
    .busy_o       (busy_o),
    .wb_addr_o    (wb_addr_o),
    .wb_ctrl_o    (wb_ctrl)
  );

  ////////////////////////////////////////
  // Load data
  ////////////////////////////////////////

  // A response for a non-last entry is the first half of a split access
  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_ctrl_i     (wb_ctrl),
    .first_phase_i (!wb_ctrl.last),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .wb_rdata_o    (wb_rdata_o)
  );

endmodule

/* rtl/lsu_txn_ctrl.sv */
// Transaction counter and stage control
module lsu_txn_ctrl #(
  parameter int DEPTH = 2   // Max outstanding bus transactions
) (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t ex_req_i,
  input  logic              misaligned_i,   // First phase of a split access
  input  logic [1:0]        offset_i,       // Address byte offset
  input  lsu_pkg::word_t    bus_addr_i,     // Address on the bus
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  logic              bus_err_i,
  output logic              bus_req_o,
  output logic              ex_ready_o,
  output logic              wb_valid_o,
  output logic              wb_err_o,
  output logic              busy_o,
  output lsu_pkg::word_t    wb_addr_o,      // Last granted address
  output lsu_pkg::wb_ctrl_t wb_ctrl_o
);

  import lsu_pkg::*;

  localparam int               CNT_W   = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q;       // Outstanding transactions
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;    // Grant this cycle
  logic             count_down;  // Response this cycle
  logic             ctrl_update; // EX request moves on to WB
  wb_ctrl_t         wb_ctrl_d;

  ////////////////////////////////////////
  // Bus request and counter
  ////////////////////////////////////////

  // Never exceed DEPTH in flight, response may not come back in the grant cycle
  assign bus_req_o  = ex_req_i.en && (cnt_q < CNT_MAX);
  assign count_up   = bus_req_o && bus_gnt_i;
  assign count_down = bus_rvalid_i;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;          // Idle, or grant and response together
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  ////////////////////////////////////////
  // Stage handshakes
  ////////////////////////////////////////

  // EX and WB advance in lock step once WB holds an access
  always_comb
  begin
    if (!ex_req_i.en)
      ex_ready_o = 1'b1;                       // Nothing to do
    else if (cnt_q == '0)
      ex_ready_o = count_up;                   // WB empty, grant is enough
    else if (cnt_q < CNT_MAX)
      ex_ready_o = count_up && bus_rvalid_i;   // WB frees as the new one issues
    else
      ex_ready_o = bus_rvalid_i;               // Already issued, wait for WB
  end

  assign ctrl_update = ex_ready_o && ex_req_i.en;

  // Only the final phase of an access reaches write-back
  assign wb_valid_o = (cnt_q != '0) && wb_ctrl_o.last && bus_rvalid_i;
  assign wb_err_o   = bus_rvalid_i && bus_err_i;

  assign busy_o = (cnt_q != '0) || bus_req_o;

  ////////////////////////////////////////
  // Write-back control
  ////////////////////////////////////////

  always_comb
  begin
    wb_ctrl_d.size     = ex_req_i.size;
    wb_ctrl_d.sign_ext = ex_req_i.sign_ext;
    wb_ctrl_d.we       = ex_req_i.we;
    wb_ctrl_d.offset   = offset_i;
    wb_ctrl_d.last     = !misaligned_i;   // A split first phase is not last
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_ctrl_o <= '0;
    else if (ctrl_update)
      wb_ctrl_o <= wb_ctrl_d;
  end

  // Address of the last granted transfer, for the error report
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_addr_o <= '0;
    else if (count_up)
      wb_addr_o <= bus_addr_i;
  end

endmodule

/* testbench/lsu_sva.sv */
// Load/store unit bus protocol assertions
module lsu_sva #(
  parameter int DEPTH = 2   // Max outstanding bus transactions
) (
  input logic              clk,
  input logic              rst_n,
  input logic              bus_req_o,
  input lsu_pkg::bus_req_t bus_o,
  input logic              bus_gnt_i,
  input logic              bus_rvalid_i,
  input logic              busy_o
);

  import lsu_pkg::*;

  int outstanding;   // Granted transfers still waiting for a response

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(bus_req_o && bus_gnt_i) - int'(bus_rvalid_i);
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= DEPTH)
    else $error("more than DEPTH transfers outstanding");

  a_full_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    (outstanding == DEPTH) |-> !bus_req_o)
    else $error("bus request raised with a full count");

  // Idle only when no transfer is in flight or waiting
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !busy_o |-> (outstanding == 0 && !bus_req_o))
    else $error("busy low while work is pending");

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(bus_o)))
    else $error("request changed while waiting for grant");

endmodule

/* testbench/tb_lsu.sv */
// Load/store unit testbench
module tb_lsu;

  import lsu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;     // Input drive after the rising edge
  localparam int DEPTH      = 2;
  localparam int N_RANDOM   = 40;
  localparam int N_OPS      = 60 + 2 * N_RANDOM;  // Upper bound on bus phases
  localparam logic [5:0] ERR_WORD = 6'd60;        // Word that answers with err

  typedef struct packed {
    logic  we;
    word_t data;
    logic  err;
    word_t addr;
  } exp_t;

  typedef struct packed {
    word_t data;
    logic  err;
    int    due;    // Cycle in which the response is driven
  } rsp_t;

  logic      clk;
  logic      rst_n;
  lsu_req_t  ex_req;
  logic      ex_misaligned_o;
  logic      ex_ready_o;
  logic      bus_req_o;
  logic      bus_gnt_i;
  logic      bus_rvalid_i;
  logic      bus_err_i;
  bus_req_t  bus_o;
  word_t     bus_rdata_i;
  logic      wb_valid_o;
  logic      wb_err_o;
  logic      busy_o;
  word_t     wb_rdata_o;
  word_t     wb_addr_o;

  word_t     mem [64];       // Bus side memory
  word_t     ref_mem [64];   // Expected memory contents
  exp_t      exp_q [$];      // Expected write-back results in order
  word_t     addr_q [$];     // Expected bus addresses in order
  rsp_t      rsp_q [$];      // Pending bus responses
  rsp_t      rsp;
  exp_t      got;
  int        seed = 66;
  int        cyc;
  int        last_due;
  logic [5:0] idx;

  lsu_top #(.DEPTH(DEPTH)) UUT (.*, .ex_req_i(ex_req));

  bind lsu_top lsu_sva #(.DEPTH(DEPTH)) u_sva (
    .clk (clk), .rst_n (rst_n), .bus_req_o (bus_req_o), .bus_o (bus_o),
    .bus_gnt_i (bus_gnt_i), .bus_rvalid_i (bus_rvalid_i), .busy_o (busy_o)
  );

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    assert (exp === act)
    else report_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic word_t fill_word(input int i);
    return (word_t'(i) * 32'h0104_1041) ^ 32'h8C3A_5E17;   // Differs in every word
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    return (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
  endfunction

  // Little endian bytes addr to addr+n-1 within a 256 byte window
  function automatic word_t load_value(input lsu_size_e size, input logic sign,
                                       input word_t addr);
    word_t      v;
    logic [7:0] b;
    int         n;
    v = '0;
    n = size_bytes(size);
    for (int i = 0; i < n; i++)
    begin
      b = addr[7:0] + 8'(i);
      v[8*i +: 8] = ref_mem[b[7:2]][8*b[1:0] +: 8];
    end
    if (sign && n == 1)
      v[31:8] = {24{v[7]}};
    else if (sign && n == 2)
      v[31:16] = {16{v[15]}};
    return v;
  endfunction

  task automatic store_ref(input lsu_size_e size, input word_t addr, input word_t wdata,
                           input logic [1:0] reg_off);
    logic [7:0] b;
    logic [1:0] lane;
    for (int i = 0; i < size_bytes(size); i++)
    begin
      b    = addr[7:0] + 8'(i);
      lane = reg_off + 2'(i);
      ref_mem[b[7:2]][8*b[1:0] +: 8] = wdata[8*lane +: 8];   // Register byte reg_off + i
    end
  endtask

  ////////////////////////////////////////
  // Clock, bus model, checker
  ////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Grant sampled mid cycle and memory written at once
  always @(negedge clk)
  begin
    if (rst_n && bus_req_o && bus_gnt_i)
    begin
      if (addr_q.size() == 0)
        report_failure("bus transfer granted with no access expected");
      check_value("bus_o.addr", addr_q.pop_front(), bus_o.addr);
      idx = bus_o.addr[7:2];
      for (int l = 0; l < BE_W; l++)
        if (bus_o.we && bus_o.be[l])
          mem[idx][8*l +: 8] = bus_o.wdata[8*l +: 8];
      rsp.data = mem[idx];
      rsp.err  = (idx == ERR_WORD);
      rsp.due  = cyc + 1 + ({$random(seed)} % 3);       // 1 to 3 cycles later
      if (rsp.due <= last_due)
        rsp.due = last_due + 1;                          // Keep order
      last_due = rsp.due;
      rsp_q.push_back(rsp);
    end
  end

  always @(posedge clk)
  begin
    cyc = cyc + 1;
    #(DRIVE_DLY);
    bus_gnt_i    = rst_n && (($random(seed) & 1) != 0);
    bus_rvalid_i = 1'b0;
    bus_err_i    = 1'b0;
    if (rsp_q.size() != 0 && rsp_q[0].due <= cyc)
    begin
      rsp          = rsp_q.pop_front();
      bus_rvalid_i = 1'b1;
      bus_rdata_i  = rsp.data;
      bus_err_i    = rsp.err;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && wb_valid_o)
    begin
      if (exp_q.size() == 0)
        report_failure("write-back result with no access expected");
      got = exp_q.pop_front();
      check_value("wb_err_o", word_t'(got.err), word_t'(wb_err_o));
      if (!got.we && !got.err)
        check_value("wb_rdata_o", got.data, wb_rdata_o);
      if (got.err)
        check_value("wb_addr_o", got.addr, wb_addr_o);
    end
  end

  initial
  begin
    #(N_OPS * 20 * CLK_PERIOD);
    report_failure("watchdog expired before all accesses completed");
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One EX phase held until accepted
  task automatic send_phase(input lsu_req_t req, input logic exp_mis);
    logic accepted;
    logic mis;
    accepted = 1'b0;
    mis      = 1'b0;
    ex_req   = req;
    while (!accepted)
    begin
      @(negedge clk);
      accepted = ex_ready_o;
      mis      = ex_misaligned_o;
      @(posedge clk);
      #(DRIVE_DLY);
    end
    check_value("ex_misaligned_o", word_t'(exp_mis), word_t'(mis));
  endtask

  task automatic issue(input logic we, input lsu_size_e size, input logic sign,
                       input word_t addr, input word_t wdata, input logic use_incr,
                       input logic [1:0] reg_off = 2'b00);
    lsu_req_t req;
    exp_t     e;
    logic     mis;
    word_t    next_addr;
    mis = (size == SIZE_WORD && addr[1:0] != 2'b00) ||
          (size == SIZE_HALF && addr[1:0] == 2'b11);
    e.we   = we;
    e.data = we ? '0 : load_value(size, sign, addr);
    e.err  = (addr[7:2] == ERR_WORD);
    e.addr = addr;
    if (we)
      store_ref(size, addr, wdata, reg_off);
    exp_q.push_back(e);
    addr_q.push_back(addr);
    next_addr = addr + 32'd4;
    if (mis)
      addr_q.push_back({next_addr[31:2], 2'b00});   // Second phase at the next word
    req            = '0;
    req.en         = 1'b1;
    req.we         = we;
    req.size       = size;
    req.sign_ext   = sign;
    req.use_incr   = use_incr;
    req.incr       = use_incr ? 32'h10 : 32'h0;
    req.base       = addr - req.incr;
    req.reg_offset = reg_off;
    req.wdata      = wdata;
    send_phase(req, mis);
    if (mis)
    begin
      req.second = 1'b1;
      req.base   = req.base + 32'd4;
      send_phase(req, 1'b0);
    end
    ex_req = '0;
  endtask

  task automatic drain();
    @(negedge clk);
    while (busy_o || exp_q.size() != 0)
      @(negedge clk);
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    ex_req       = '0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_err_i    = 1'b0;
    bus_rdata_i  = '0;
    cyc          = 0;
    last_due     = 0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (10) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    // Aligned stores then word loads that read back untouched lanes
    issue(1, SIZE_WORD, 0, 32'h40, 32'h1234_5678, 0);
    issue(1, SIZE_HALF, 0, 32'h46, 32'hABCD_8F01, 1);
    issue(1, SIZE_BYTE, 0, 32'h49, 32'h0000_00E7, 0);
    for (int a = 32'h40; a <= 32'h48; a += 4)
      issue(0, SIZE_WORD, 0, a, '0, 0);

    // Byte and halfword at every offset
    issue(1, SIZE_WORD, 0, 32'h80, 32'h80FF_7F01, 0);
    issue(1, SIZE_WORD, 0, 32'h84, 32'hF00D_8001, 0);
    for (int off = 0; off < 4; off++)
      for (int s = 0; s < 2; s++)
      begin
        issue(0, SIZE_BYTE, s[0], 32'h80 + off, '0, 0);
        if (off < 3)
          issue(0, SIZE_HALF, s[0], 32'h80 + off, '0, s[0]);
      end

    // Misaligned loads
    for (int off = 1; off < 4; off++)
      issue(0, SIZE_WORD, 0, 32'h80 + off, '0, 0);
    issue(0, SIZE_HALF, 0, 32'h83, '0, 0);
    issue(0, SIZE_HALF, 1, 32'h83, '0, 1);

    // Misaligned stores checked by aligned loads of both words
    issue(1, SIZE_WORD, 0, 32'hA1, 32'hC0DE_1357, 0);
    issue(1, SIZE_WORD, 0, 32'hB2, 32'h2468_ACE0, 1);
    issue(1, SIZE_WORD, 0, 32'hC3, 32'h9ABC_DEF0, 0);
    issue(1, SIZE_HALF, 0, 32'hD3, 32'h0000_5AA5, 0);
    for (int a = 32'hA0; a <= 32'hD4; a += 4)
      issue(0, SIZE_WORD, 0, a, '0, 0);

    // Back-to-back random accesses in words 16 to 47
    for (int k = 0; k < N_RANDOM; k++)
      issue(($random(seed) & 1) != 0, lsu_size_e'({$random(seed)} % 3),
            ($random(seed) & 1) != 0, 32'd64 + ({$random(seed)} % 120),
            $random(seed), ($random(seed) & 1) != 0, 2'($random(seed)));

    // Error word isolated so its grant is the last one
    drain();
    issue(0, SIZE_WORD, 0, {24'h0, ERR_WORD, 2'b00}, '0, 0);
    drain();

    if (exp_q.size() == 0 && addr_q.size() == 0 && rsp_q.size() == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
      report_failure("accesses left outstanding at the end of the test");
  end

endmodule
